// File: Bender.yml
package:
  name: conv_feeder

sources:
  - feeder_pkg.sv
  - line_buffer_ram.sv
  - row_writer.sv
  - window_reader.sv
  - wavefront_skew.sv
  - feeder_top.sv
  - target: simulation
    files:
      - tb_feeder.sv

// File: feeder_pkg.sv
package feeder_pkg;

	// lane split of one stored word
	localparam int LANE_W = 8;
	localparam int LANES = 2;
	localparam int WORD_W = LANE_W * LANES;	// ram word

	// frame geometry, fixed at build time
	localparam int IN_COLS = 8;	// pixels per row
	localparam int IN_ROWS = 8;
	localparam int CHANS = 2;	// words per pixel
	localparam int KSIZE = 3;	// square kernel

	// line buffer ring
	localparam int BUF_ROWS = 4;	// power of two, slot wraps on its own
	localparam int ROW_WORDS = IN_COLS * CHANS;
	localparam int DEPTH = BUF_ROWS * ROW_WORDS;
	localparam int ADDR_W = $clog2(DEPTH);

	// row counters must reach IN_ROWS itself, not just IN_ROWS-1
	localparam int ROW_CNT_W = $clog2(IN_ROWS + 1);

endpackage

// File: feeder_top.sv
`timescale 1ns/1ps

module feeder_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_valid,
	input  logic [feeder_pkg::WORD_W-1:0]   i_data,
	input  logic                            i_stride,	// 0 is stride 1, 1 is stride 2
	output logic                            o_ready,
	output logic [feeder_pkg::LANE_W-1:0]   o_lane_data [feeder_pkg::LANES],
	output logic [feeder_pkg::LANES-1:0]    o_lane_valid,
	output logic                            o_frame_done
);

	logic we;
	logic [feeder_pkg::ADDR_W-1:0] waddr;
	logic [feeder_pkg::ROW_CNT_W-1:0] rows_filled;
	logic [feeder_pkg::ROW_CNT_W-1:0] rows_released;
	logic re;
	logic [feeder_pkg::ADDR_W-1:0] raddr;
	logic [feeder_pkg::WORD_W-1:0] rdata;
	logic rd_valid;	// lines up with rdata

	row_writer u_writer (
		.clk             (clk),
		.rst             (rst),
		.i_valid         (i_valid),
		.i_frame_done    (o_frame_done),
		.i_rows_released (rows_released),
		.o_ready         (o_ready),
		.o_we            (we),
		.o_waddr         (waddr),
		.o_rows_filled   (rows_filled)
	);

	line_buffer_ram u_ram (
		.clk     (clk),
		.i_we    (we),
		.i_waddr (waddr),
		.i_wdata (i_data),
		.i_re    (re),
		.i_raddr (raddr),
		.o_rdata (rdata)
	);

	window_reader u_reader (
		.clk             (clk),
		.rst             (rst),
		.i_stride        (i_stride),
		.i_rows_filled   (rows_filled),
		.o_re            (re),
		.o_raddr         (raddr),
		.o_rows_released (rows_released),
		.o_frame_done    (o_frame_done)
	);

	// ram read latency
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= re;
		end
	end

	wavefront_skew u_skew (
		.clk          (clk),
		.rst          (rst),
		.i_valid      (rd_valid),
		.i_word       (rdata),
		.o_lane_data  (o_lane_data),
		.o_lane_valid (o_lane_valid)
	);

endmodule

// File: line_buffer_ram.sv
`timescale 1ns/1ps

module line_buffer_ram (
	input  logic                            clk,
	input  logic                            i_we,
	input  logic [feeder_pkg::ADDR_W-1:0]   i_waddr,
	input  logic [feeder_pkg::WORD_W-1:0]   i_wdata,
	input  logic                            i_re,
	input  logic [feeder_pkg::ADDR_W-1:0]   i_raddr,
	output logic [feeder_pkg::WORD_W-1:0]   o_rdata
);

	// four rows of pixel words, slot-major
	logic [feeder_pkg::WORD_W-1:0] mem [feeder_pkg::DEPTH];

	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// registered read, data one cycle after i_re
	always_ff @(posedge clk) begin
		if (i_re) begin
			o_rdata <= mem[i_raddr];
		end
	end

endmodule

// File: row_writer.sv
`timescale 1ns/1ps

module row_writer (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_valid,
	input  logic                              i_frame_done,
	input  logic [feeder_pkg::ROW_CNT_W-1:0]  i_rows_released,
	output logic                              o_ready,
	output logic                              o_we,
	output logic [feeder_pkg::ADDR_W-1:0]     o_waddr,
	output logic [feeder_pkg::ROW_CNT_W-1:0]  o_rows_filled
);

	logic [$clog2(feeder_pkg::ROW_WORDS)-1:0] wr_word;	// word offset in row
	logic [$clog2(feeder_pkg::BUF_ROWS)-1:0] wr_slot;	// ring slot being filled
	logic [feeder_pkg::ROW_CNT_W-1:0] rows_held;
	logic row_done;

	// rows the reader still needs, complete ones only
	assign rows_held = o_rows_filled - i_rows_released;

	// next row goes into the slot of row (filled - BUF_ROWS), which must be released
	assign o_ready = (rows_held < feeder_pkg::BUF_ROWS) &&
		(o_rows_filled < feeder_pkg::IN_ROWS);
	assign o_we = i_valid && o_ready;
	assign row_done = o_we && (wr_word == feeder_pkg::ROW_WORDS - 1);

	assign o_waddr = feeder_pkg::ADDR_W'(wr_slot * feeder_pkg::ROW_WORDS + wr_word);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_word <= '0;
			wr_slot <= '0;
			o_rows_filled <= '0;
		end else if (i_frame_done) begin
			// new frame restarts at row 0, slot 0
			wr_word <= '0;
			wr_slot <= '0;
			o_rows_filled <= '0;
		end else if (o_we) begin
			if (row_done) begin
				wr_word <= '0;
				wr_slot <= wr_slot + 1'b1;	// wraps mod BUF_ROWS
				o_rows_filled <= o_rows_filled + 1'b1;
			end else begin
				wr_word <= wr_word + 1'b1;
			end
		end
	end

	// a write must never land on a row the reader has not released
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		o_we |-> ((wr_slot - i_rows_released) % feeder_pkg::BUF_ROWS >= rows_held))
		else $error("write into held slot, filled %0d released %0d",
			o_rows_filled, i_rows_released);

endmodule

// File: sources.f
feeder_pkg.sv
line_buffer_ram.sv
row_writer.sv
window_reader.sv
wavefront_skew.sv
feeder_top.sv
tb_feeder.sv

// File: tb_feeder.sv
`timescale 1ns/1ps

module tb_feeder;

	localparam int CLK_NS = 8;
	localparam int RESET_CYC = 5;
	localparam int NUM_FRAMES = 3;	// stride 1, stride 2, stride 1
	localparam int FRAME_WORDS = feeder_pkg::IN_ROWS * feeder_pkg::ROW_WORDS;
	localparam int MAX_OUT = feeder_pkg::IN_ROWS - feeder_pkg::KSIZE + 1;
	localparam int MAX_READS = MAX_OUT * MAX_OUT * feeder_pkg::KSIZE * feeder_pkg::KSIZE *
		feeder_pkg::CHANS;
	// every read of a stride 1 frame, input at half rate, 200 cycles spare
	localparam int FRAME_CYC = MAX_READS + 2 * FRAME_WORDS + 200;
	localparam int WATCHDOG_NS = (RESET_CYC + NUM_FRAMES * FRAME_CYC) * CLK_NS;

	logic clk = 1'b0;
	logic rst;
	logic i_valid;
	logic [feeder_pkg::WORD_W-1:0] i_data;
	logic i_stride;
	logic o_ready;
	logic [feeder_pkg::LANE_W-1:0] o_lane_data [feeder_pkg::LANES];
	logic [feeder_pkg::LANES-1:0] o_lane_valid;
	logic o_frame_done;

	logic [feeder_pkg::LANE_W-1:0] exp_q [feeder_pkg::LANES][$];	// one queue per lane
	logic [31:0] rng = 32'd82282;
	int words_in;	// words accepted in this frame
	int lane0_cnt;
	int done_cnt;
	bit stall_seen;

	always #(CLK_NS / 2) clk = ~clk;

	feeder_top u_dut (
		.clk          (clk),
		.rst          (rst),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.i_stride     (i_stride),
		.o_ready      (o_ready),
		.o_lane_data  (o_lane_data),
		.o_lane_valid (o_lane_valid),
		.o_frame_done (o_frame_done)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// row, column, channel and lane number packed into one lane byte
	function automatic logic [feeder_pkg::LANE_W-1:0] coord_byte(input int row, input int col,
		input int ch, input int lane);
		return {row[2:0], col[2:0], ch[0], lane[0]};
	endfunction

	function automatic logic [feeder_pkg::WORD_W-1:0] pixel_word(input int idx);
		int row;
		int col;
		int ch;
		logic [feeder_pkg::WORD_W-1:0] w;
		row = idx / feeder_pkg::ROW_WORDS;
		col = (idx % feeder_pkg::ROW_WORDS) / feeder_pkg::CHANS;
		ch = idx % feeder_pkg::CHANS;
		for (int l = 0; l < feeder_pkg::LANES; l++) begin
			w[l*feeder_pkg::LANE_W +: feeder_pkg::LANE_W] = coord_byte(row, col, ch, l);
		end
		return w;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("ERROR @ %0t ns: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	// window order: out row, out col, kernel row, kernel col, channel
	task automatic load_expected(input int stride);
		int n_out;
		n_out = (feeder_pkg::IN_ROWS - feeder_pkg::KSIZE) / stride + 1;
		for (int orow = 0; orow < n_out; orow++)
			for (int oc = 0; oc < n_out; oc++)
				for (int kr = 0; kr < feeder_pkg::KSIZE; kr++)
					for (int kc = 0; kc < feeder_pkg::KSIZE; kc++)
						for (int ch = 0; ch < feeder_pkg::CHANS; ch++)
							for (int l = 0; l < feeder_pkg::LANES; l++)
								exp_q[l].push_back(coord_byte(orow * stride + kr,
									oc * stride + kc, ch, l));
	endtask

	// entered 1 ns after a rising edge, leaves the same way
	task automatic send_frame();
		int idx;
		bit took;
		idx = 0;
		while (idx < FRAME_WORDS) begin
			rng = xorshift(rng);
			i_valid = (rng[1:0] != 2'b00);	// idle about one cycle in four
			i_data = pixel_word(idx);
			@(negedge clk);
			took = i_valid && o_ready;
			@(posedge clk);
			if (took) begin
				idx++;
				words_in++;
			end
			#1;
		end
		i_valid = 1'b0;
	endtask

	// scoreboard, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			for (int l = 0; l < feeder_pkg::LANES; l++) begin
				if (o_lane_valid[l]) begin
					assert (exp_q[l].size() != 0)
						else report_mismatch($sformatf("lane %0d valid with no word expected", l));
					assert (o_lane_data[l] == exp_q[l][0])
						else report_mismatch($sformatf("lane %0d got %h, expected %h",
							l, o_lane_data[l], exp_q[l][0]));
					void'(exp_q[l].pop_front());
				end
			end
			if (o_lane_valid[0])
				lane0_cnt++;
			if (o_frame_done)
				done_cnt++;
			// four rows written and none released yet
			if (words_in / feeder_pkg::ROW_WORDS == feeder_pkg::BUF_ROWS &&
				u_dut.rows_released == 0) begin
				assert (!o_ready) else report_mismatch("o_ready high while the ring is full");
				stall_seen = 1'b1;
			end
			if (words_in == FRAME_WORDS && done_cnt == 0) begin
				assert (!o_ready) else report_mismatch("o_ready high after the last row");
			end
		end
	end

	// lane l trails lane 0 by l cycles
	for (genvar l = 1; l < feeder_pkg::LANES; l++) begin : g_skew_chk
		a_lane_skew: assert property (@(posedge clk) disable iff (rst)
			o_lane_valid[l] == $past(o_lane_valid[0], l))
			else report_mismatch($sformatf("lane %0d valid breaks its %0d-cycle skew", l, l));
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all frames were read out");
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		int stride;
		int n_out;
		rst = 1'b1;
		i_valid = 1'b0;
		i_data = '0;
		i_stride = 1'b0;
		words_in = 0;
		lane0_cnt = 0;
		done_cnt = 0;
		stall_seen = 1'b0;
		repeat (RESET_CYC) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		assert (o_ready && o_lane_valid == '0 && !o_frame_done)
			else report_mismatch("outputs not idle after reset");
		@(posedge clk);
		#1;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			stride = (f % 2) + 1;
			n_out = (feeder_pkg::IN_ROWS - feeder_pkg::KSIZE) / stride + 1;
			words_in = 0;
			lane0_cnt = 0;
			done_cnt = 0;
			stall_seen = 1'b0;
			i_stride = (stride == 2);
			load_expected(stride);
			send_frame();
			while (done_cnt == 0) begin
				@(posedge clk);
			end
			// last lane valid comes LANES cycles after frame done
			repeat (feeder_pkg::LANES) @(posedge clk);
			#1;
			assert (done_cnt == 1)
				else report_mismatch($sformatf("frame %0d: %0d done pulses", f, done_cnt));
			assert (lane0_cnt == n_out * n_out * feeder_pkg::KSIZE * feeder_pkg::KSIZE *
				feeder_pkg::CHANS)
				else report_mismatch($sformatf("frame %0d: %0d lane 0 words", f, lane0_cnt));
			assert (stall_seen)
				else report_mismatch($sformatf("frame %0d: ring never filled", f));
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: wavefront_skew.sv
`timescale 1ns/1ps

module wavefront_skew (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_valid,
	input  logic [feeder_pkg::WORD_W-1:0]   i_word,
	output logic [feeder_pkg::LANE_W-1:0]   o_lane_data [feeder_pkg::LANES],
	output logic [feeder_pkg::LANES-1:0]    o_lane_valid
);

	// lane l goes through l+1 stages
	for (genvar l = 0; l < feeder_pkg::LANES; l++) begin : g_lane
		logic [feeder_pkg::LANE_W-1:0] data_sr [0:l];
		logic [l:0] vld_sr;

		always_ff @(posedge clk) begin
			data_sr[0] <= i_word[l*feeder_pkg::LANE_W +: feeder_pkg::LANE_W];
			for (int s = 1; s <= l; s++) begin
				data_sr[s] <= data_sr[s-1];
			end
		end

		// valid travels with its lane
		always_ff @(posedge clk) begin
			if (rst) begin
				vld_sr <= '0;
			end else begin
				vld_sr[0] <= i_valid;
				for (int s = 1; s <= l; s++) begin
					vld_sr[s] <= vld_sr[s-1];
				end
			end
		end

		assign o_lane_data[l] = data_sr[l];
		assign o_lane_valid[l] = vld_sr[l];
	end

endmodule

// File: window_reader.sv
`timescale 1ns/1ps

module window_reader (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_stride,
	input  logic [feeder_pkg::ROW_CNT_W-1:0]  i_rows_filled,
	output logic                              o_re,
	output logic [feeder_pkg::ADDR_W-1:0]     o_raddr,
	output logic [feeder_pkg::ROW_CNT_W-1:0]  o_rows_released,
	output logic                              o_frame_done
);

	// loop counters, innermost first
	logic [$clog2(feeder_pkg::CHANS)-1:0] ch;
	logic [$clog2(feeder_pkg::KSIZE)-1:0] kc;
	logic [$clog2(feeder_pkg::KSIZE)-1:0] kr;
	logic [feeder_pkg::ROW_CNT_W-1:0] oc;
	logic [feeder_pkg::ROW_CNT_W-1:0] orow;

	logic frame_run;	// first read of frame issued
	logic stride_q;
	logic stride_sel;
	logic fin;	// last read done, waiting for the tail rows
	logic [feeder_pkg::ROW_CNT_W-1:0] out_dim;
	logic [feeder_pkg::ROW_CNT_W-1:0] step;
	logic [feeder_pkg::ROW_CNT_W-1:0] top_row;
	logic [feeder_pkg::ROW_CNT_W-1:0] rd_row;
	logic [feeder_pkg::ROW_CNT_W-1:0] rd_col;
	logic ch_last;
	logic kc_last;
	logic kr_last;
	logic oc_last;
	logic orow_last;
	logic row_end;
	logic last_rd;
	logic all_in;

	assign stride_sel = frame_run ? stride_q : i_stride;
	assign step = stride_sel ? feeder_pkg::ROW_CNT_W'(2) : feeder_pkg::ROW_CNT_W'(1);

	// (IN_ROWS - KSIZE) / stride + 1, stride is 1 or 2
	assign out_dim = feeder_pkg::ROW_CNT_W'(
		((feeder_pkg::IN_ROWS - feeder_pkg::KSIZE) >> stride_sel) + 1);

	assign top_row = orow << stride_sel;
	assign rd_row = top_row + feeder_pkg::ROW_CNT_W'(kr);
	assign rd_col = (oc << stride_sel) + feeder_pkg::ROW_CNT_W'(kc);

	// slot base + pixel base + channel
	assign o_raddr = feeder_pkg::ADDR_W'(
		(rd_row % feeder_pkg::BUF_ROWS) * feeder_pkg::ROW_WORDS +
		rd_col * feeder_pkg::CHANS + ch);

	assign all_in = (i_rows_filled == feeder_pkg::ROW_CNT_W'(feeder_pkg::IN_ROWS));

	// wait until every row of the current window row band is written
	assign o_re = !fin && !o_frame_done &&
		(i_rows_filled >= top_row + feeder_pkg::ROW_CNT_W'(feeder_pkg::KSIZE));

	assign ch_last = (ch == feeder_pkg::CHANS - 1);
	assign kc_last = (kc == feeder_pkg::KSIZE - 1);
	assign kr_last = (kr == feeder_pkg::KSIZE - 1);
	assign oc_last = (oc == out_dim - 1'b1);
	assign orow_last = (orow == out_dim - 1'b1);
	assign row_end = o_re && ch_last && kc_last && kr_last && oc_last;
	assign last_rd = row_end && orow_last;

	always_ff @(posedge clk) begin
		if (rst) begin
			ch <= '0;
			kc <= '0;
			kr <= '0;
			oc <= '0;
			orow <= '0;
		end else if (o_re) begin
			ch <= ch_last ? '0 : ch + 1'b1;
			if (ch_last) begin
				kc <= kc_last ? '0 : kc + 1'b1;
				if (kc_last) begin
					kr <= kr_last ? '0 : kr + 1'b1;
					if (kr_last) begin
						oc <= oc_last ? '0 : oc + 1'b1;
						if (oc_last) begin
							orow <= orow_last ? '0 : orow + 1'b1;
						end
					end
				end
			end
		end
	end

	// stride is frozen once the first window starts
	always_ff @(posedge clk) begin
		if (o_re && !frame_run) begin
			stride_q <= i_stride;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_run <= 1'b0;
			fin <= 1'b0;
			o_frame_done <= 1'b0;
			o_rows_released <= '0;
		end else begin
			o_frame_done <= 1'b0;
			if (o_re) begin
				frame_run <= 1'b1;
			end
			if (o_frame_done) begin
				frame_run <= 1'b0;
				o_rows_released <= '0;	// writer clears its count on the same edge
			end
			if (last_rd || fin) begin
				// with stride 2 the last row may still be arriving
				if (all_in) begin
					o_frame_done <= 1'b1;
					o_rows_released <= feeder_pkg::ROW_CNT_W'(feeder_pkg::IN_ROWS);
					fin <= 1'b0;
				end else begin
					fin <= 1'b1;
				end
			end else if (row_end) begin
				o_rows_released <= o_rows_released + step;	// drop rows above next top
			end
		end
	end

	a_read_held_row: assert property (@(posedge clk) disable iff (rst)
		o_re |-> (rd_row < i_rows_filled) && (rd_row >= o_rows_released))
		else $error("read of row %0d, filled %0d released %0d",
			rd_row, i_rows_filled, o_rows_released);

	a_done_single: assert property (@(posedge clk) disable iff (rst)
		o_frame_done |=> !o_frame_done)
		else $error("frame done high for two cycles");

endmodule
